// File: Makefile
# Verilator build and run of the translation service testbench

VERILATOR ?= verilator
TOP ?= tb_vtp_svc
FLAGS ?= --assert
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line appears"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
verilog/vtp_pkg.sv
verilog/vtp_ifs.sv
verilog/vtp_fifo.sv
verilog/vtp_port_arbiter.sv
verilog/vtp_tlb.sv
verilog/vtp_walk_ctrl.sv
verilog/vtp_svc.sv
sim/vtp_svc_asserts.sv
sim/tb_vtp_svc.sv

// File: sim/tb_vtp_svc.sv
// Testbench for the translation service
// Pattern-driven clients, random-latency walker model and a response scoreboard

`timescale 1ns/1ps
`default_nettype none

module tb_vtp_svc
    import vtp_pkg::*;
();

    localparam int N_PORTS = 4;
    localparam int CLK_PERIOD = 4;
    // Depth of each client input FIFO
    localparam int IN_FIFO_DEPTH = 4;
    // Walker translation rule
    localparam t_page_pa PA_XOR = 20'h5a5a5;

    // Outstanding request and walk record
    typedef struct packed {
        logic [1:0] port;
        t_tag tag;
        t_page_va va;
    } t_entry;

    logic clk;
    logic reset;
    logic [N_PORTS-1:0] lookup_en;
    t_page_va [N_PORTS-1:0] lookup_va;
    t_tag [N_PORTS-1:0] lookup_tag;
    logic [N_PORTS-1:0] lookup_rdy;
    logic [N_PORTS-1:0] rsp_valid;
    t_page_pa rsp_pa;
    t_tag rsp_tag;
    logic walk_req_en;
    t_page_va walk_req_va;
    logic [1:0] walk_req_port;
    t_tag walk_req_tag;
    logic walk_req_rdy;
    logic walk_rsp_en;
    t_page_va walk_rsp_va;
    t_page_pa walk_rsp_pa;
    logic [1:0] walk_rsp_port;
    t_tag walk_rsp_tag;

    // Pattern lines with one entry per line in each queue
    int pat_phase[$];
    int pat_port[$];
    t_page_va pat_va[$];
    t_tag pat_tag[$];

    t_entry pend[$];
    t_entry walk_q[$];
    int cur_phase;

    vtp_svc #(.N_PORTS(N_PORTS)) u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================================================
    // Checks and helpers
    // ========================================================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "%s check failed", name);
        end
    endtask

    task automatic stop_with_failure(input string what);
        $display("error at %0t: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "%s", what);
    endtask

    // Comment and blank lines fail to scan and are skipped
    task automatic load_patterns();
        int fd;
        int n;
        int ph;
        int port;
        t_page_va va;
        t_tag tag;
        string line;
        fd = $fopen("sim/vtp_patterns.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open sim/vtp_patterns.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                n = $sscanf(line, "%d %d %h %h", ph, port, va, tag);
                if (n == 4)
                begin
                    pat_phase.push_back(ph);
                    pat_port.push_back(port);
                    pat_va.push_back(va);
                    pat_tag.push_back(tag);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int find_pending(input logic [1:0] port, input t_tag tag);
        for (int i = 0; i < pend.size(); i++)
            if (pend[i].port == port && pend[i].tag == tag)
                return i;
        return -1;
    endfunction

    function automatic int count_pending(input logic [1:0] port);
        int n;
        n = 0;
        foreach (pend[i])
            if (pend[i].port == port)
                n++;
        return n;
    endfunction

    // One client issues its own lines of one phase in file order
    task automatic drive_port(input int p, input int ph);
        int unsigned gap;
        for (int i = 0; i < pat_port.size(); i++)
        begin
            if (pat_port[i] == p && pat_phase[i] == ph)
            begin
                gap = $urandom % 3;
                repeat (gap)
                begin
                    @(posedge clk);
                    #1;
                end
                // Only offered while the input FIFO has room
                while (!lookup_rdy[p])
                begin
                    @(posedge clk);
                    #1;
                end
                lookup_en[p] = 1'b1;
                lookup_va[p] = pat_va[i];
                lookup_tag[p] = pat_tag[i];
                pend.push_back('{port: 2'(p), tag: pat_tag[i], va: pat_va[i]});
                @(posedge clk);
                #1;
                lookup_en[p] = 1'b0;
            end
        end
    endtask

    // Walker model with one walk at a time, random latency and ready drops
    task automatic run_walker();
        t_entry w;
        int unsigned wait_cycles;
        forever
        begin
            @(posedge clk);
            #1;
            if (walk_q.size() > 0)
            begin
                walk_req_rdy = 1'b0;
                w = walk_q.pop_front();
                wait_cycles = 1 + ($urandom % 8);
                repeat (wait_cycles) @(posedge clk);
                #1;
                walk_rsp_en = 1'b1;
                walk_rsp_va = w.va;
                walk_rsp_pa = w.va ^ PA_XOR;
                walk_rsp_port = w.port;
                walk_rsp_tag = w.tag;
                @(posedge clk);
                #1;
                walk_rsp_en = 1'b0;
            end
            else if (($urandom % 8) == 0)
            begin
                walk_req_rdy = 1'b0;
                repeat (1 + ($urandom % 6)) @(posedge clk);
            end
            else
                walk_req_rdy = 1'b1;
        end
    endtask

    // ========================================================================
    // Scoreboard sampled at the falling edge
    // ========================================================================

    always @(negedge clk)
    begin
        int idx;
        if (!reset)
        begin
            // Fewer outstanding than the input FIFO depth means that FIFO has room
            for (int p = 0; p < N_PORTS; p++)
                if (count_pending(2'(p)) < IN_FIFO_DEPTH)
                    check_value("lookup_rdy", 32'(1), 32'(lookup_rdy[p]));
            if ($countones(rsp_valid) > 1)
                stop_with_failure("more than one port responded in one cycle");
            for (int p = 0; p < N_PORTS; p++)
            begin
                if (rsp_valid[p])
                begin
                    idx = find_pending(2'(p), rsp_tag);
                    if (idx < 0)
                        stop_with_failure($sformatf(
                            "response on port %0d with tag %h that is not outstanding",
                            p, rsp_tag));
                    else
                    begin
                        check_value("rsp_pa", 32'(pend[idx].va ^ PA_XOR), 32'(rsp_pa));
                        pend.delete(idx);
                    end
                end
            end
            // Walks only for phase-1 misses still waiting
            if (walk_req_en)
            begin
                idx = find_pending(walk_req_port, walk_req_tag);
                if (cur_phase != 1)
                    stop_with_failure("walk request issued in phase 2");
                else if (idx < 0)
                    stop_with_failure("walk request for a tag that is not outstanding");
                else
                begin
                    check_value("walk_req_va", 32'(pend[idx].va), 32'(walk_req_va));
                    walk_q.push_back(pend[idx]);
                end
            end
        end
    end

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial
    begin
        int unsigned seed_ret;
        int watch_cycles;
        seed_ret = $urandom(32'h19fb_e8bb);
        reset = 1'b1;
        lookup_en = '0;
        lookup_va = '0;
        lookup_tag = '0;
        walk_req_rdy = 1'b1;
        walk_rsp_en = 1'b0;
        walk_rsp_va = '0;
        walk_rsp_pa = '0;
        walk_rsp_port = '0;
        walk_rsp_tag = '0;
        cur_phase = 0;
        load_patterns();
        watch_cycles = pat_port.size() * 100;
        fork
            begin
                repeat (watch_cycles) @(posedge clk);
                $display("timeout: run did not finish within %0d cycles", watch_cycles);
                $display(">>> FAIL");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            run_walker();
        join_none
        // Phase 2 starts only once phase 1 is fully answered
        for (int ph = 1; ph <= 2; ph++)
        begin
            cur_phase = ph;
            fork
                drive_port(0, ph);
                drive_port(1, ph);
                drive_port(2, ph);
                drive_port(3, ph);
            join
            while (pend.size() != 0)
                @(posedge clk);
            #1;
        end
        // Quiet tail catches stray responses
        repeat (20) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/vtp_patterns.txt
// phase port vpage(hex) tag(hex), tags unique per port
// phase 1 pages sit in distinct TLB sets, phase 2 only reuses them
1 0 12340 1
1 1 0abc1 1
1 2 55552 1
1 3 7f013 1
1 0 00a24 2
1 1 3c3c5 2
1 2 8e7e6 2
1 3 12340 2
1 0 0abc1 3
1 1 55552 3
1 2 7f013 3
1 3 00a24 3
1 0 3c3c5 4
1 1 8e7e6 4
2 0 55552 5
2 1 12340 5
2 2 00a24 5
2 3 8e7e6 5
2 0 7f013 6
2 1 0abc1 6
2 2 3c3c5 6
2 3 12340 6

// File: sim/vtp_svc_asserts.sv
// Concurrent checks on the translation service ports
// Walker request spacing, one-hot responses, quiet outputs in reset

`timescale 1ns/1ps
`default_nettype none

module vtp_svc_asserts
    import vtp_pkg::*;
#(
    parameter int N_PORTS = DEFAULT_N_PORTS
)
(
    input  logic clk,
    input  logic reset,
    input  logic walk_req_en,
    input  logic [N_PORTS-1:0] rsp_valid
);

    // Dequeue guard leaves a gap after every walk request
    walk_req_spaced: assert property (@(posedge clk) disable iff (reset)
        walk_req_en |=> !walk_req_en)
        else $error("walk_req_en high in two consecutive cycles");

    rsp_valid_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rsp_valid))
        else $error("rsp_valid has more than one port set");

    // Outputs are cleared one edge into reset
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !walk_req_en && (rsp_valid == '0))
        else $error("walk_req_en or rsp_valid active during reset");

endmodule

bind vtp_svc vtp_svc_asserts #(.N_PORTS(N_PORTS)) u_asserts
(
    .clk(clk),
    .reset(reset),
    .walk_req_en(walk_req_en),
    .rsp_valid(rsp_valid)
);

`default_nettype wire

// File: verilog/vtp_fifo.sv
// Synchronous FIFO with a registered head entry
// not_empty follows the head register, almost_full at THRESHOLD free slots

`timescale 1ns/1ps
`default_nettype none

module vtp_fifo
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES = 4,
    parameter int THRESHOLD = 1
)
(
    input  logic clk,
    input  logic reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,
    output logic almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    // Total held, head included
    logic [CNT_BITS-1:0] cnt;
    // Held in storage behind the head
    logic [CNT_BITS-1:0] mem_cnt;

    logic head_load;
    logic mem_pop;
    logic mem_push;

    // Pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(N_ENTRIES - 1)) ? '0 : p + 1'b1;
    endfunction

    // Head takes new data when empty or being popped
    assign head_load = !not_empty || deq_en;
    assign mem_pop = head_load && (mem_cnt != '0);
    // Empty storage and free head: data goes straight to the head
    assign mem_push = enq_en && !(head_load && (mem_cnt == '0));

    assign not_full = cnt < CNT_BITS'(N_ENTRIES);
    assign almost_full = cnt >= CNT_BITS'(N_ENTRIES - THRESHOLD);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt <= '0;
            mem_cnt <= '0;
            not_empty <= 1'b0;
        end
        else
        begin
            if (mem_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (mem_pop)
                rd_ptr <= ptr_next(rd_ptr);
            mem_cnt <= mem_cnt + CNT_BITS'(mem_push) - CNT_BITS'(mem_pop);
            cnt <= cnt + CNT_BITS'(enq_en) - CNT_BITS'(deq_en);
            if (head_load)
                not_empty <= mem_pop || enq_en;
        end
    end

    // Storage and head payload
    always_ff @(posedge clk)
    begin
        if (mem_push)
            mem[wr_ptr] <= enq_data;
        if (mem_pop)
            first <= mem[rd_ptr];
        else if (head_load && enq_en)
            first <= enq_data;
    end

endmodule

`default_nettype wire

// File: verilog/vtp_ifs.sv
// Interfaces inside the translation service
// Merged request stream from the arbiter and the TLB lookup/fill bus

`timescale 1ns/1ps
`default_nettype none

// Head of the merged request FIFO, popped by a deq pulse
interface vtp_req_stream_if
    import vtp_pkg::*;
#(
    parameter int N_PORTS = DEFAULT_N_PORTS
)
();
    t_lookup_req req;
    logic [$clog2(N_PORTS)-1:0] port;
    logic valid;
    // Only while valid, pops in the same cycle
    logic deq;

    modport source (output req, output port, output valid, input deq);
    modport sink (input req, input port, input valid, output deq);
endinterface

// Lookup side from the service, fill side from the walk controller
interface vtp_tlb_if
    import vtp_pkg::*;
();
    logic lookup_en;
    t_page_va lookup_va;
    // Two cycles after lookup_en
    logic lookup_hit;
    logic lookup_miss;
    t_page_pa lookup_pa;

    logic fill_en;
    t_page_va fill_va;
    t_page_pa fill_pa;

    modport server (input lookup_en, input lookup_va,
                    output lookup_hit, output lookup_miss, output lookup_pa,
                    input fill_en, input fill_va, input fill_pa);
    modport client (output lookup_en, output lookup_va,
                    input lookup_hit, input lookup_miss, input lookup_pa);
    modport fill (output fill_en, output fill_va, output fill_pa);
endinterface

`default_nettype wire

// File: verilog/vtp_pkg.sv
// Shared types and sizes for the virtual-to-physical translation service
// Page numbers, client tags and the lookup request/response records

`default_nettype none

package vtp_pkg;

    // Page number and tag widths
    localparam int VA_PAGE_BITS = 20;
    localparam int PA_PAGE_BITS = 20;
    localparam int TAG_BITS = 4;

    typedef logic [VA_PAGE_BITS-1:0] t_page_va;
    typedef logic [PA_PAGE_BITS-1:0] t_page_pa;
    typedef logic [TAG_BITS-1:0] t_tag;

    // Request from a client, tag is echoed in the response
    typedef struct packed {
        t_page_va page_va;
        t_tag tag;
    } t_lookup_req;

    typedef struct packed {
        t_page_pa page_pa;
        t_tag tag;
    } t_lookup_rsp;

    // Defaults for the top level, lookup latency is fixed
    localparam int DEFAULT_N_PORTS = 4;
    localparam int DEFAULT_TLB_SETS = 16;
    localparam int TLB_PIPE_STAGES = 2;

endpackage

`default_nettype wire

// File: verilog/vtp_port_arbiter.sv
// Client port front end
// Per-port input FIFOs, registered round-robin grant, merged request FIFO

`timescale 1ns/1ps
`default_nettype none

module vtp_port_arbiter
    import vtp_pkg::*;
#(
    parameter int N_PORTS = DEFAULT_N_PORTS
)
(
    input  logic clk,
    input  logic reset,

    input  logic [N_PORTS-1:0] lookup_en,
    input  t_page_va [N_PORTS-1:0] lookup_va,
    input  t_tag [N_PORTS-1:0] lookup_tag,
    output logic [N_PORTS-1:0] lookup_rdy,

    vtp_req_stream_if.source stream
);

    localparam int IDX_BITS = $clog2(N_PORTS);
    typedef logic [IDX_BITS-1:0] t_port_idx;

    // ========================================================================
    // Input FIFOs
    // ========================================================================

    t_lookup_req new_req [N_PORTS];
    logic [N_PORTS-1:0] new_req_rdy;
    logic [N_PORTS-1:0] new_req_sel;
    logic [N_PORTS-1:0] arb_grant;
    logic [N_PORTS-1:0] arb_grant_q;
    t_port_idx arb_idx;
    t_port_idx arb_idx_q;
    t_port_idx rr_last;
    logic merged_almost_full;

    // Grant is a cycle old, so the FIFO may have drained meanwhile
    assign new_req_sel = arb_grant_q & new_req_rdy;

    for (genvar p = 0; p < N_PORTS; p++)
    begin : g_in
        vtp_fifo
        #(
            .N_DATA_BITS($bits(t_lookup_req)),
            .N_ENTRIES(4)
        )
        u_in_fifo
        (
            .clk,
            .reset,
            .enq_data({lookup_va[p], lookup_tag[p]}),
            .enq_en(lookup_en[p]),
            .not_full(lookup_rdy[p]),
            .almost_full(),
            .first(new_req[p]),
            .deq_en(new_req_sel[p]),
            .not_empty(new_req_rdy[p])
        );
    end

    // ========================================================================
    // Round-robin arbitration
    // ========================================================================

    // Search starts one past the last winner
    always_comb
    begin
        logic found;
        t_port_idx cand;

        found = 1'b0;
        arb_grant = '0;
        arb_idx = rr_last;
        for (int i = 1; i <= N_PORTS; i++)
        begin
            cand = t_port_idx'((int'(rr_last) + i) % N_PORTS);
            // Hold off while the merged FIFO can't absorb the in-flight ones
            if (!found && new_req_rdy[cand] && !merged_almost_full)
            begin
                found = 1'b1;
                arb_grant[cand] = 1'b1;
                arb_idx = cand;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            arb_grant_q <= '0;
            rr_last <= '0;
        end
        else
        begin
            arb_grant_q <= arb_grant;
            if (|arb_grant)
                rr_last <= arb_idx;
        end
        arb_idx_q <= arb_idx;
    end

    // ========================================================================
    // Stage register and merged FIFO
    // ========================================================================

    logic winner_en;
    t_lookup_req winner_req;
    t_port_idx winner_port;
    logic [$bits(t_lookup_req)+IDX_BITS-1:0] merged_first;

    always_ff @(posedge clk)
    begin
        if (reset)
            winner_en <= 1'b0;
        else
            winner_en <= new_req_sel[arb_idx_q];
        winner_req <= new_req[arb_idx_q];
        winner_port <= arb_idx_q;
    end

    // Up to three grants in flight, hence 2 of 4 as the threshold
    vtp_fifo
    #(
        .N_DATA_BITS($bits(t_lookup_req) + IDX_BITS),
        .N_ENTRIES(4),
        .THRESHOLD(2)
    )
    u_merged_fifo
    (
        .clk,
        .reset,
        .enq_data({winner_req, winner_port}),
        .enq_en(winner_en),
        .not_full(),
        .almost_full(merged_almost_full),
        .first(merged_first),
        .deq_en(stream.deq),
        .not_empty(stream.valid)
    );

    assign {stream.req, stream.port} = merged_first;

endmodule

`default_nettype wire

// File: verilog/vtp_svc.sv
// Shared virtual-to-physical translation service, top level
// Arbitrates client ports into one TLB, walks misses, routes the answers

`timescale 1ns/1ps
`default_nettype none

module vtp_svc
    import vtp_pkg::*;
#(
    parameter int N_PORTS = DEFAULT_N_PORTS,
    parameter int TLB_SETS = DEFAULT_TLB_SETS
)
(
    input  logic clk,
    input  logic reset,

    // Clients
    input  logic [N_PORTS-1:0] lookup_en,
    input  t_page_va [N_PORTS-1:0] lookup_va,
    input  t_tag [N_PORTS-1:0] lookup_tag,
    output logic [N_PORTS-1:0] lookup_rdy,
    output logic [N_PORTS-1:0] rsp_valid,
    output t_page_pa rsp_pa,
    output t_tag rsp_tag,

    // Page-table walker
    output logic walk_req_en,
    output t_page_va walk_req_va,
    output logic [$clog2(N_PORTS)-1:0] walk_req_port,
    output t_tag walk_req_tag,
    input  logic walk_req_rdy,
    input  logic walk_rsp_en,
    input  t_page_va walk_rsp_va,
    input  t_page_pa walk_rsp_pa,
    input  logic [$clog2(N_PORTS)-1:0] walk_rsp_port,
    input  t_tag walk_rsp_tag
);

    localparam int IDX_BITS = $clog2(N_PORTS);

    vtp_req_stream_if #(.N_PORTS(N_PORTS)) stream();
    vtp_tlb_if tlb_if();

    vtp_port_arbiter #(.N_PORTS(N_PORTS)) u_arb
    (
        .clk,
        .reset,
        .lookup_en,
        .lookup_va,
        .lookup_tag,
        .lookup_rdy,
        .stream(stream)
    );

    vtp_tlb #(.TLB_SETS(TLB_SETS)) u_tlb
    (
        .clk,
        .reset,
        .tlb(tlb_if)
    );

    // ========================================================================
    // Lookup issue and processed FIFOs
    // ========================================================================

    logic issue;
    logic preq_almost_full;
    logic proc_deq;
    t_lookup_req proc_req;
    logic [IDX_BITS-1:0] proc_port;

    // Throttle keeps room for every lookup still inside the TLB
    assign issue = stream.valid && !preq_almost_full;
    assign stream.deq = issue;
    assign tlb_if.lookup_en = issue;
    assign tlb_if.lookup_va = stream.req.page_va;

    // Request kept for the miss path and for its tag and port
    vtp_fifo
    #(
        .N_DATA_BITS($bits(t_lookup_req) + IDX_BITS),
        .N_ENTRIES(TLB_PIPE_STAGES + 4),
        .THRESHOLD(3)
    )
    u_proc_req_fifo
    (
        .clk,
        .reset,
        .enq_data({stream.req, stream.port}),
        .enq_en(issue),
        .not_full(),
        .almost_full(preq_almost_full),
        .first({proc_req, proc_port}),
        .deq_en(proc_deq),
        .not_empty()
    );

    // TLB result registered once, then queued in step with the requests
    logic res_hit;
    logic res_miss;
    t_page_pa res_pa;
    logic prsp_valid;
    logic prsp_hit;
    t_page_pa prsp_pa;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            res_hit <= 1'b0;
            res_miss <= 1'b0;
        end
        else
        begin
            res_hit <= tlb_if.lookup_hit;
            res_miss <= tlb_if.lookup_miss;
        end
        res_pa <= tlb_if.lookup_pa;
    end

    vtp_fifo
    #(
        .N_DATA_BITS(PA_PAGE_BITS + 1),
        .N_ENTRIES(TLB_PIPE_STAGES + 4),
        .THRESHOLD(3)
    )
    u_proc_rsp_fifo
    (
        .clk,
        .reset,
        .enq_data({res_pa, res_hit}),
        .enq_en(res_hit || res_miss),
        .not_full(),
        .almost_full(),
        .first({prsp_pa, prsp_hit}),
        .deq_en(proc_deq),
        .not_empty(prsp_valid)
    );

    // ========================================================================
    // Miss path and response merge
    // ========================================================================

    logic miss_en;
    logic miss_rdy;
    logic hit_send;
    logic wrsp_valid;
    t_lookup_rsp wrsp;
    logic [IDX_BITS-1:0] wrsp_idx;

    // Walker answers win, a hit waits at the FIFO head
    assign miss_en = prsp_valid && !prsp_hit && miss_rdy;
    assign hit_send = prsp_valid && prsp_hit && !wrsp_valid;
    assign proc_deq = hit_send || miss_en;

    vtp_walk_ctrl #(.N_PORTS(N_PORTS)) u_walk
    (
        .clk,
        .reset,
        .miss_en,
        .miss_req(proc_req),
        .miss_port(proc_port),
        .miss_rdy,
        .walk_req_en,
        .walk_req_va,
        .walk_req_port,
        .walk_req_tag,
        .walk_req_rdy,
        .walk_rsp_en,
        .walk_rsp_va,
        .walk_rsp_pa,
        .walk_rsp_port,
        .walk_rsp_tag,
        .walk_rsp_valid(wrsp_valid),
        .walk_rsp(wrsp),
        .walk_rsp_idx(wrsp_idx),
        .tlb(tlb_if)
    );

    // One-hot valid, data shared by all ports
    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= '0;
        else
        begin
            rsp_valid <= '0;
            if (wrsp_valid)
                rsp_valid[wrsp_idx] <= 1'b1;
            else if (hit_send)
                rsp_valid[proc_port] <= 1'b1;
        end

        if (wrsp_valid)
        begin
            rsp_pa <= wrsp.page_pa;
            rsp_tag <= wrsp.tag;
        end
        else
        begin
            rsp_pa <= prsp_pa;
            rsp_tag <= proc_req.tag;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vtp_tlb.sv
// Direct-mapped TLB
// Two-stage lookup (array read, then compare) and a single-entry fill port

`timescale 1ns/1ps
`default_nettype none

module vtp_tlb
    import vtp_pkg::*;
#(
    parameter int TLB_SETS = DEFAULT_TLB_SETS
)
(
    input  logic clk,
    input  logic reset,

    vtp_tlb_if.server tlb
);

    localparam int SET_BITS = $clog2(TLB_SETS);
    localparam int VTAG_BITS = VA_PAGE_BITS - SET_BITS;

    // Set index is the low page bits, the rest is the stored tag
    logic [TLB_SETS-1:0] valid;
    logic [VTAG_BITS-1:0] vtag [TLB_SETS];
    t_page_pa ppage [TLB_SETS];

    logic [SET_BITS-1:0] lookup_set;
    logic [SET_BITS-1:0] fill_set;

    assign lookup_set = tlb.lookup_va[SET_BITS-1:0];
    assign fill_set = tlb.fill_va[SET_BITS-1:0];

    // Stage 1 state
    logic s1_en;
    logic [VTAG_BITS-1:0] s1_vtag;
    logic s1_rd_valid;
    logic [VTAG_BITS-1:0] s1_rd_vtag;
    t_page_pa s1_rd_pa;

    // Fill lands at the clock edge, so a same-cycle lookup sees old contents
    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= '0;
        else if (tlb.fill_en)
            valid[fill_set] <= 1'b1;

        if (tlb.fill_en)
        begin
            vtag[fill_set] <= tlb.fill_va[VA_PAGE_BITS-1:SET_BITS];
            ppage[fill_set] <= tlb.fill_pa;
        end
    end

    // Stage 1 reads the set
    always_ff @(posedge clk)
    begin
        if (reset)
            s1_en <= 1'b0;
        else
            s1_en <= tlb.lookup_en;
        s1_vtag <= tlb.lookup_va[VA_PAGE_BITS-1:SET_BITS];
        s1_rd_valid <= valid[lookup_set];
        s1_rd_vtag <= vtag[lookup_set];
        s1_rd_pa <= ppage[lookup_set];
    end

    // Stage 2 compares, exactly one of hit or miss per lookup
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tlb.lookup_hit <= 1'b0;
            tlb.lookup_miss <= 1'b0;
        end
        else
        begin
            tlb.lookup_hit <= s1_en && s1_rd_valid && (s1_rd_vtag == s1_vtag);
            tlb.lookup_miss <= s1_en && !(s1_rd_valid && (s1_rd_vtag == s1_vtag));
        end
        tlb.lookup_pa <= s1_rd_pa;
    end

endmodule

`default_nettype wire

// File: verilog/vtp_walk_ctrl.sv
// Miss handling toward the external page-table walker
// Queues misses, issues walk requests, returns answers and fills the TLB

`timescale 1ns/1ps
`default_nettype none

module vtp_walk_ctrl
    import vtp_pkg::*;
#(
    parameter int N_PORTS = DEFAULT_N_PORTS
)
(
    input  logic clk,
    input  logic reset,

    // Misses from the service pipeline
    input  logic miss_en,
    input  t_lookup_req miss_req,
    input  logic [$clog2(N_PORTS)-1:0] miss_port,
    output logic miss_rdy,

    // Walker bus
    output logic walk_req_en,
    output t_page_va walk_req_va,
    output logic [$clog2(N_PORTS)-1:0] walk_req_port,
    output t_tag walk_req_tag,
    input  logic walk_req_rdy,
    input  logic walk_rsp_en,
    input  t_page_va walk_rsp_va,
    input  t_page_pa walk_rsp_pa,
    input  logic [$clog2(N_PORTS)-1:0] walk_rsp_port,
    input  t_tag walk_rsp_tag,

    // Answers toward the client merge
    output logic walk_rsp_valid,
    output t_lookup_rsp walk_rsp,
    output logic [$clog2(N_PORTS)-1:0] walk_rsp_idx,

    vtp_tlb_if.fill tlb
);

    localparam int IDX_BITS = $clog2(N_PORTS);

    t_lookup_req q_req;
    logic [IDX_BITS-1:0] q_port;
    logic q_rdy;
    logic q_deq;

    // Queue lets hits flow around outstanding misses
    vtp_fifo
    #(
        .N_DATA_BITS($bits(t_lookup_req) + IDX_BITS),
        .N_ENTRIES(8)
    )
    u_walk_queue
    (
        .clk,
        .reset,
        .enq_data({miss_req, miss_port}),
        .enq_en(miss_en),
        .not_full(miss_rdy),
        .almost_full(),
        .first({q_req, q_port}),
        .deq_en(q_deq),
        .not_empty(q_rdy)
    );

    // No dequeue right after a request, so never two in a row
    assign q_deq = q_rdy && walk_req_rdy && !walk_req_en;

    always_ff @(posedge clk)
    begin
        if (reset)
            walk_req_en <= 1'b0;
        else
            walk_req_en <= q_deq;
        walk_req_va <= q_req.page_va;
        walk_req_port <= q_port;
        walk_req_tag <= q_req.tag;
    end

    // Client answer and TLB fill go out together one cycle after the walker
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            walk_rsp_valid <= 1'b0;
            tlb.fill_en <= 1'b0;
        end
        else
        begin
            walk_rsp_valid <= walk_rsp_en;
            tlb.fill_en <= walk_rsp_en;
        end
        walk_rsp.page_pa <= walk_rsp_pa;
        walk_rsp.tag <= walk_rsp_tag;
        walk_rsp_idx <= walk_rsp_port;
        tlb.fill_va <= walk_rsp_va;
        tlb.fill_pa <= walk_rsp_pa;
    end

endmodule

`default_nettype wire
